/* common/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// datapath widths
`define MEM_DW              32
`define MEM_LANES           4
`define REG_AW              5

// cp0 register numbers
`define CP0_STATUS_ADDR     5'd12
`define CP0_CAUSE_ADDR      5'd13

// exception flags from execute, one bit per source
`define EXC_FLAG_W          5
`define EXC_SYSCALL_BIT     0
`define EXC_INVALID_BIT     1
`define EXC_TRAP_BIT        2
`define EXC_OV_BIT          3
`define EXC_ERET_BIT        4

// status / cause fields
`define STATUS_IE_BIT       0
`define STATUS_EXL_BIT      1
`define IM_LSB              8   // IM in status, IP in cause
`define IM_MSB              15

`endif

/* common/mem_op_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package mem_op_pkg;

    // memory op codes as issued by execute
    typedef enum logic [7:0]
    {
        NOP = 8'b0000_0000,
        LB  = 8'b1110_0000,
        LBU = 8'b1110_0100,
        LH  = 8'b1110_0001,
        LHU = 8'b1110_0101,
        LW  = 8'b1110_0011,
        SB  = 8'b1110_1000,
        SH  = 8'b1110_1001,
        SW  = 8'b1110_1011,
        LL  = 8'b1111_0000,
        SC  = 8'b1111_1000
    } mem_op_e;

    // one data word, big endian
    // index 0 is the most significant byte / halfword
    typedef union packed
    {
        logic [0:`MEM_LANES-1][7:0]      bytes;
        logic [0:`MEM_LANES/2-1][15:0]   halves;
    } mem_word_u;

endpackage

`default_nettype wire

/* common/cp0_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package cp0_pkg;

    // exception codes handed to cp0 / ctrl
    typedef enum logic [`MEM_DW-1:0]
    {
        NONE    = 32'h0000_0000,
        INT     = 32'h0000_0001,
        SYSCALL = 32'h0000_0008,
        INVALID = 32'h0000_000a,
        OV      = 32'h0000_000c,
        TRAP    = 32'h0000_000d,
        ERET    = 32'h0000_000e
    } excep_code_e;

    typedef logic [`REG_AW-1:0] cp0_addr_t;   // cp0 register number

endpackage

`default_nettype wire

/* lsu/ram_request.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module ram_request
(
    input  wire mem_op_pkg::mem_op_e    op_i,
    input  wire [`MEM_DW-1:0]           addr_i,
    input  wire [`MEM_DW-1:0]           reg2_i,
    input  wire                         sc_pass_i,
    input  wire                         excep_taken_i,

    output logic                        mem_ce_o,
    output logic                        mem_we_o,
    output logic [`MEM_DW-1:0]          mem_addr_o,
    output logic [`MEM_DW-1:0]          mem_data_o,
    output logic [`MEM_LANES-1:0]       mem_sel_o
);

    logic [`MEM_LANES-1:0]  byte_lane;
    logic [`MEM_LANES-1:0]  half_lane;
    logic                   we_raw;     // before exception cancel
    mem_op_pkg::mem_word_u  st_word;

    // ------------------------------------------------------------------------
    // lane selects, big endian: offset 0 hits the msb lane
    // ------------------------------------------------------------------------
    assign byte_lane = {1'b1, {(`MEM_LANES-1){1'b0}}} >> addr_i[1:0];
    assign half_lane = addr_i[1] ? 4'b0011 : 4'b1100;

    always_comb
    begin
        mem_ce_o   = 1'b0;
        we_raw     = 1'b0;
        mem_addr_o = '0;
        mem_sel_o  = '1;        // don't care on reads
        st_word    = '0;
        case (op_i)
            mem_op_pkg::LB, mem_op_pkg::LBU:
            begin
                mem_ce_o   = 1'b1;
                mem_addr_o = addr_i;
                mem_sel_o  = byte_lane;
            end
            mem_op_pkg::LH, mem_op_pkg::LHU:
            begin
                mem_ce_o   = 1'b1;
                mem_addr_o = addr_i;
                mem_sel_o  = half_lane;
            end
            mem_op_pkg::LW, mem_op_pkg::LL:
            begin
                mem_ce_o   = 1'b1;
                mem_addr_o = addr_i;
            end
            mem_op_pkg::SB:
            begin
                mem_ce_o      = 1'b1;
                we_raw        = 1'b1;
                mem_addr_o    = addr_i;
                mem_sel_o     = byte_lane;
                st_word.bytes = {`MEM_LANES{reg2_i[7:0]}};  // same byte on every lane
            end
            mem_op_pkg::SH:
            begin
                mem_ce_o       = 1'b1;
                we_raw         = 1'b1;
                mem_addr_o     = addr_i;
                mem_sel_o      = half_lane;
                st_word.halves = {(`MEM_LANES/2){reg2_i[15:0]}};
            end
            mem_op_pkg::SW:
            begin
                mem_ce_o   = 1'b1;
                we_raw     = 1'b1;
                mem_addr_o = addr_i;
                st_word    = reg2_i;
            end
            mem_op_pkg::SC:
            begin
                // failed sc never touches the ram
                if (sc_pass_i)
                begin
                    mem_ce_o   = 1'b1;
                    we_raw     = 1'b1;
                    mem_addr_o = addr_i;
                    st_word    = reg2_i;
                end
            end
            default:
            begin
            end
        endcase
    end

    assign mem_data_o = st_word;
    assign mem_we_o   = we_raw & ~excep_taken_i;   // exception cancels the write

endmodule

`default_nettype wire

/* lsu/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module load_align
(
    input  wire mem_op_pkg::mem_op_e    op_i,
    input  wire [`MEM_DW-1:0]           addr_i,
    input  wire [`MEM_DW-1:0]           rdata_i,
    input  wire [`MEM_DW-1:0]           wdata_i,   // alu result for non-loads

    output logic [`MEM_DW-1:0]          load_wdata_o
);

    mem_op_pkg::mem_word_u  rword;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;

    assign rword   = rdata_i;
    assign ld_byte = rword.bytes[addr_i[1:0]];
    assign ld_half = rword.halves[addr_i[1]];   // bit 0 assumed clear

    // ------------------------------------------------------------------------
    // extend to register width
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (op_i)
            mem_op_pkg::LB:
                load_wdata_o = {{(`MEM_DW-8){ld_byte[7]}}, ld_byte};
            mem_op_pkg::LBU:
                load_wdata_o = {{(`MEM_DW-8){1'b0}}, ld_byte};
            mem_op_pkg::LH:
                load_wdata_o = {{(`MEM_DW-16){ld_half[15]}}, ld_half};
            mem_op_pkg::LHU:
                load_wdata_o = {{(`MEM_DW-16){1'b0}}, ld_half};
            mem_op_pkg::LW, mem_op_pkg::LL:
                load_wdata_o = rdata_i;             // whole word
            default:
                load_wdata_o = wdata_i;
        endcase
    end

endmodule

`default_nettype wire

/* excep/excep_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module excep_arbiter
(
    input  wire [`MEM_DW-1:0]           inst_addr_i,
    input  wire [`EXC_FLAG_W-1:0]       excep_flags_i,
    input  wire [`MEM_DW-1:0]           cp0_status_i,
    input  wire [`MEM_DW-1:0]           cp0_cause_i,
    input  wire                         wb_cp0_we_i,
    input  wire cp0_pkg::cp0_addr_t     wb_cp0_waddr_i,
    input  wire [`MEM_DW-1:0]           wb_cp0_wdata_i,

    output cp0_pkg::excep_code_e        excep_code_o,
    output logic                        excep_taken_o
);

    logic [`MEM_DW-1:0] status_fwd;
    logic [`MEM_DW-1:0] cause_fwd;
    logic               int_pending;
    logic               inst_valid;

    // ------------------------------------------------------------------------
    // cp0 forward from write-back
    // ------------------------------------------------------------------------
    assign status_fwd = (wb_cp0_we_i && wb_cp0_waddr_i == `CP0_STATUS_ADDR) ?
                        wb_cp0_wdata_i : cp0_status_i;

    always_comb
    begin
        cause_fwd = cp0_cause_i;
        if (wb_cp0_we_i && wb_cp0_waddr_i == `CP0_CAUSE_ADDR)
            cause_fwd[`IM_LSB+1:`IM_LSB] = wb_cp0_wdata_i[`IM_LSB+1:`IM_LSB]; // sw intr only
    end

    // ie set, not already in exception level, some unmasked line pending
    assign int_pending = status_fwd[`STATUS_IE_BIT] & ~status_fwd[`STATUS_EXL_BIT] &
                         (|(status_fwd[`IM_MSB:`IM_LSB] & cause_fwd[`IM_MSB:`IM_LSB]));

    assign inst_valid = (inst_addr_i != '0);   // zero means bubble / flushed

    // ------------------------------------------------------------------------
    // fixed priority
    // ------------------------------------------------------------------------
    always_comb
    begin
        excep_code_o = cp0_pkg::NONE;
        if (inst_valid)
        begin
            if (int_pending)
                excep_code_o = cp0_pkg::INT;
            else if (excep_flags_i[`EXC_TRAP_BIT])
                excep_code_o = cp0_pkg::TRAP;
            else if (excep_flags_i[`EXC_OV_BIT])
                excep_code_o = cp0_pkg::OV;
            else if (excep_flags_i[`EXC_SYSCALL_BIT])
                excep_code_o = cp0_pkg::SYSCALL;
            else if (excep_flags_i[`EXC_INVALID_BIT])
                excep_code_o = cp0_pkg::INVALID;
            else if (excep_flags_i[`EXC_ERET_BIT])
                excep_code_o = cp0_pkg::ERET;
        end
    end

    assign excep_taken_o = (excep_code_o != cp0_pkg::NONE);

endmodule

`default_nettype wire

/* logic/llsc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module llsc_ctrl
(
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire mem_op_pkg::mem_op_e    op_i,
    input  wire                         excep_taken_i,

    output logic                        sc_pass_o,
    output logic                        sc_sel_o,
    output logic [`MEM_DW-1:0]          sc_wdata_o
);

    logic link_q;   // set by ll, consumed by a passing sc

    // ------------------------------------------------------------------------
    // store-conditional decision
    // ------------------------------------------------------------------------
    assign sc_sel_o   = (op_i == mem_op_pkg::SC);
    assign sc_pass_o  = sc_sel_o & link_q;
    assign sc_wdata_o = {{(`MEM_DW-1){1'b0}}, sc_pass_o};   // 1 = success, 0 = fail

    // ------------------------------------------------------------------------
    // link bit
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            link_q <= 1'b0;
        end
        else if (excep_taken_i)
        begin
            // any exception breaks the atomic sequence
            link_q <= 1'b0;
        end
        else if (op_i == mem_op_pkg::LL)
        begin
            link_q <= 1'b1;
        end
        else if (sc_pass_o)
        begin
            link_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_wb_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_wb_reg
(
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire [`REG_AW-1:0]           wd_i,
    input  wire                         wreg_i,
    input  wire [`MEM_DW-1:0]           load_wdata_i,
    input  wire                         sc_sel_i,
    input  wire [`MEM_DW-1:0]           sc_wdata_i,
    input  wire                         excep_taken_i,

    output logic [`REG_AW-1:0]          wb_wd_o,
    output logic                        wb_wreg_o,
    output logic [`MEM_DW-1:0]          wb_wdata_o
);

    logic [`MEM_DW-1:0] wdata_nxt;

    // sc writes its status flag instead of ram data
    assign wdata_nxt = sc_sel_i ? sc_wdata_i : load_wdata_i;

    always_ff @(posedge clk)
    begin
        if (rst_i || excep_taken_i)
        begin
            wb_wreg_o  <= 1'b0;     // flushed slot
            wb_wdata_o <= '0;
        end
        else
        begin
            wb_wreg_o  <= wreg_i;
            wb_wdata_o <= wdata_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_wd_o <= wd_i;
    end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_stage
(
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire [`MEM_DW-1:0]           inst_addr_i,
    input  wire mem_op_pkg::mem_op_e    aluop_i,
    input  wire [`MEM_DW-1:0]           mem_addr_i,
    input  wire [`MEM_DW-1:0]           reg2_i,
    input  wire [`MEM_DW-1:0]           wdata_i,
    input  wire [`REG_AW-1:0]           wd_i,
    input  wire                         wreg_i,
    input  wire [`EXC_FLAG_W-1:0]       excep_flags_i,
    input  wire [`MEM_DW-1:0]           cp0_status_i,
    input  wire [`MEM_DW-1:0]           cp0_cause_i,
    input  wire                         wb_cp0_we_i,
    input  wire cp0_pkg::cp0_addr_t     wb_cp0_waddr_i,
    input  wire [`MEM_DW-1:0]           wb_cp0_wdata_i,
    input  wire [`MEM_DW-1:0]           mem_data_i,

    // data ram
    output logic                        mem_ce_o,
    output logic                        mem_we_o,
    output logic [`MEM_DW-1:0]          mem_addr_o,
    output logic [`MEM_DW-1:0]          mem_data_o,
    output logic [`MEM_LANES-1:0]       mem_sel_o,
    // to cp0 / ctrl
    output cp0_pkg::excep_code_e        excep_code_o,
    // write-back
    output logic [`REG_AW-1:0]          wb_wd_o,
    output logic                        wb_wreg_o,
    output logic [`MEM_DW-1:0]          wb_wdata_o
);

    logic               excep_taken;
    logic               sc_pass;
    logic               sc_sel;
    logic [`MEM_DW-1:0] sc_wdata;
    logic [`MEM_DW-1:0] load_wdata;

    // ------------------------------------------------------------------------
    // exception arbitration
    // ------------------------------------------------------------------------
    excep_arbiter u_excep_arbiter
    (
        .inst_addr_i    (inst_addr_i),
        .excep_flags_i  (excep_flags_i),
        .cp0_status_i   (cp0_status_i),
        .cp0_cause_i    (cp0_cause_i),
        .wb_cp0_we_i    (wb_cp0_we_i),
        .wb_cp0_waddr_i (wb_cp0_waddr_i),
        .wb_cp0_wdata_i (wb_cp0_wdata_i),
        .excep_code_o   (excep_code_o),
        .excep_taken_o  (excep_taken)
    );

    llsc_ctrl u_llsc_ctrl
    (
        .clk            (clk),
        .rst_i          (rst_i),
        .op_i           (aluop_i),
        .excep_taken_i  (excep_taken),
        .sc_pass_o      (sc_pass),
        .sc_sel_o       (sc_sel),
        .sc_wdata_o     (sc_wdata)
    );

    // ------------------------------------------------------------------------
    // load / store unit
    // ------------------------------------------------------------------------
    ram_request u_ram_request
    (
        .op_i           (aluop_i),
        .addr_i         (mem_addr_i),
        .reg2_i         (reg2_i),
        .sc_pass_i      (sc_pass),
        .excep_taken_i  (excep_taken),
        .mem_ce_o       (mem_ce_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o),
        .mem_sel_o      (mem_sel_o)
    );

    load_align u_load_align
    (
        .op_i           (aluop_i),
        .addr_i         (mem_addr_i),
        .rdata_i        (mem_data_i),      // ram answers in the same cycle
        .wdata_i        (wdata_i),
        .load_wdata_o   (load_wdata)
    );

    mem_wb_reg u_mem_wb_reg
    (
        .clk            (clk),
        .rst_i          (rst_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .load_wdata_i   (load_wdata),
        .sc_sel_i       (sc_sel),
        .sc_wdata_i     (sc_wdata),
        .excep_taken_i  (excep_taken),
        .wb_wd_o        (wb_wd_o),
        .wb_wreg_o      (wb_wreg_o),
        .wb_wdata_o     (wb_wdata_o)
    );

endmodule

`default_nettype wire

/* verif/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    // one table row: stimulus plus expected values
    typedef struct
    {
        mem_op_pkg::mem_op_e    op;
        logic                   rst;
        logic [31:0]            inst_addr;
        logic [31:0]            addr;
        logic [31:0]            reg2;
        logic [31:0]            wdata;
        logic [31:0]            rdata;      // word the ram model returns
        logic [4:0]             flags;
        logic [31:0]            status;
        logic [31:0]            cause;
        logic                   cp0_we;
        logic [4:0]             cp0_waddr;
        logic [31:0]            cp0_wdata;
        logic [4:0]             wd;
        logic                   wreg;
        logic                   exp_ce;
        logic                   exp_we;
        logic [3:0]             exp_sel;
        logic [31:0]            exp_addr;
        logic [31:0]            exp_mdata;
        logic [31:0]            exp_code;
        logic                   exp_wreg;
        logic [31:0]            exp_wdata;
    } row_t;

    logic                   clk;
    logic                   rst_i;
    logic [31:0]            inst_addr;
    mem_op_pkg::mem_op_e    aluop;
    logic [31:0]            mem_addr;
    logic [31:0]            reg2;
    logic [31:0]            wdata;
    logic [4:0]             wd;
    logic                   wreg;
    logic [4:0]             excep_flags;
    logic [31:0]            cp0_status;
    logic [31:0]            cp0_cause;
    logic                   wb_cp0_we;
    logic [4:0]             wb_cp0_waddr;
    logic [31:0]            wb_cp0_wdata;
    logic [31:0]            mem_rdata;
    logic [31:0]            cur_rdata;

    wire                    mem_ce;
    wire                    mem_we;
    wire [31:0]             mem_addr_out;
    wire [31:0]             mem_wdata_out;
    wire [3:0]              mem_sel;
    cp0_pkg::excep_code_e   excep_code;
    wire [4:0]              wb_wd;
    wire                    wb_wreg;
    wire [31:0]             wb_wdata;

    row_t                   rows[$];
    string                  names[$];
    bit                     row_bad[$];
    bit                     table_ready = 0;
    int                     errors = 0;
    int                     checks = 0;

    mem_stage u_dut
    (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_addr_i    (inst_addr),
        .aluop_i        (aluop),
        .mem_addr_i     (mem_addr),
        .reg2_i         (reg2),
        .wdata_i        (wdata),
        .wd_i           (wd),
        .wreg_i         (wreg),
        .excep_flags_i  (excep_flags),
        .cp0_status_i   (cp0_status),
        .cp0_cause_i    (cp0_cause),
        .wb_cp0_we_i    (wb_cp0_we),
        .wb_cp0_waddr_i (wb_cp0_waddr),
        .wb_cp0_wdata_i (wb_cp0_wdata),
        .mem_data_i     (mem_rdata),
        .mem_ce_o       (mem_ce),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr_out),
        .mem_data_o     (mem_wdata_out),
        .mem_sel_o      (mem_sel),
        .excep_code_o   (excep_code),
        .wb_wd_o        (wb_wd),
        .wb_wreg_o      (wb_wreg),
        .wb_wdata_o     (wb_wdata)
    );

    // combinational ram, answers in the same cycle
    assign mem_rdata = mem_ce ? cur_rdata : 32'h0;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // row builders
    // ------------------------------------------------------------------------
    function automatic row_t blank_row();
        row_t r;
        r.op        = mem_op_pkg::NOP;
        r.rst       = 1'b0;
        r.inst_addr = 32'h0000_0400 + 32'(rows.size() * 4);
        r.addr      = $urandom();
        r.reg2      = $urandom();
        r.wdata     = $urandom();
        r.rdata     = $urandom();
        r.flags     = 5'b0;
        r.status    = 32'h0;
        r.cause     = 32'h0;
        r.cp0_we    = 1'b0;
        r.cp0_waddr = 5'd0;
        r.cp0_wdata = 32'h0;
        r.wd        = 5'($urandom());
        r.wreg      = 1'b1;
        r.exp_ce    = 1'b0;
        r.exp_we    = 1'b0;
        r.exp_sel   = 4'b1111;
        r.exp_addr  = 32'h0;
        r.exp_mdata = 32'h0;
        r.exp_code  = 32'h0;
        r.exp_wreg  = 1'b1;
        r.exp_wdata = r.wdata;      // non-loads pass the alu result
        return r;
    endfunction

    // one-hot lane of a byte access, offset 0 is the msb lane
    function automatic logic [3:0] byte_lane_sel(input int off);
        case (off)
            0:       return 4'b1000;
            1:       return 4'b0100;
            2:       return 4'b0010;
            default: return 4'b0001;
        endcase
    endfunction

    // big endian: offset 0 is bits 31:24
    function automatic row_t load_row(input mem_op_pkg::mem_op_e op, input int off);
        row_t        r;
        logic [7:0]  b;
        logic [15:0] h;
        int          msb_pos;
        r          = blank_row();
        r.op       = op;
        r.addr     = 32'h0000_1000 | 32'(off);
        r.exp_ce   = 1'b1;
        r.exp_addr = r.addr;
        if (op == mem_op_pkg::LH || op == mem_op_pkg::LHU)
            msb_pos = 16 * (1 - off / 2) + 15;
        else
            msb_pos = 8 * (3 - off) + 7;
        r.rdata[msb_pos] = (off < 2);     // negative at low offsets, positive at high
        b          = 8'(r.rdata >> (8 * (3 - off)));
        h          = 16'(r.rdata >> (16 * (1 - off / 2)));
        case (op)
            mem_op_pkg::LB:
            begin
                r.exp_sel   = byte_lane_sel(off);
                r.exp_wdata = {{24{b[7]}}, b};
            end
            mem_op_pkg::LBU:
            begin
                r.exp_sel   = byte_lane_sel(off);
                r.exp_wdata = {24'h0, b};
            end
            mem_op_pkg::LH:
            begin
                r.exp_sel   = (off == 0) ? 4'b1100 : 4'b0011;
                r.exp_wdata = {{16{h[15]}}, h};
            end
            mem_op_pkg::LHU:
            begin
                r.exp_sel   = (off == 0) ? 4'b1100 : 4'b0011;
                r.exp_wdata = {16'h0, h};
            end
            default:
                r.exp_wdata = r.rdata;      // lw and ll
        endcase
        return r;
    endfunction

    function automatic row_t store_row(input mem_op_pkg::mem_op_e op, input int off);
        row_t r;
        r          = blank_row();
        r.op       = op;
        r.addr     = 32'h0000_2000 | 32'(off);
        r.wreg     = 1'b0;
        r.exp_wreg = 1'b0;
        r.exp_ce   = 1'b1;
        r.exp_we   = 1'b1;
        r.exp_addr = r.addr;
        case (op)
            mem_op_pkg::SB:
            begin
                r.exp_sel   = byte_lane_sel(off);
                r.exp_mdata = {4{r.reg2[7:0]}};
            end
            mem_op_pkg::SH:
            begin
                r.exp_sel   = (off == 0) ? 4'b1100 : 4'b0011;
                r.exp_mdata = {2{r.reg2[15:0]}};
            end
            default:
                r.exp_mdata = r.reg2;
        endcase
        return r;
    endfunction

    function automatic row_t excep_row(input logic [4:0] flags, input logic [31:0] status,
                                       input logic [31:0] cause, input logic cp0_we,
                                       input logic [4:0] waddr, input logic [31:0] cp0_wdata,
                                       input logic [31:0] code);
        row_t r;
        r           = blank_row();
        r.flags     = flags;
        r.status    = status;
        r.cause     = cause;
        r.cp0_we    = cp0_we;
        r.cp0_waddr = waddr;
        r.cp0_wdata = cp0_wdata;
        r.exp_code  = code;
        if (code != 32'h0)
        begin
            r.exp_wreg  = 1'b0;     // flushed
            r.exp_wdata = 32'h0;
        end
        return r;
    endfunction

    // taken exception on an existing row
    function automatic row_t cancel(input row_t base);
        row_t r;
        r           = base;
        r.flags     = 5'b00100;     // trap
        r.exp_code  = 32'h0000_000d;
        r.exp_we    = 1'b0;
        r.exp_wreg  = 1'b0;
        r.exp_wdata = 32'h0;
        return r;
    endfunction

    task automatic add(input string n, input row_t r);
        rows.push_back(r);
        names.push_back(n);
        row_bad.push_back(1'b0);
    endtask

    task automatic build_table();
        row_t r;
        for (int off = 0; off < 4; off++)
        begin
            add($sformatf("lb_off%0d", off), load_row(mem_op_pkg::LB, off));
            add($sformatf("lbu_off%0d", off), load_row(mem_op_pkg::LBU, off));
            add($sformatf("sb_off%0d", off), store_row(mem_op_pkg::SB, off));
        end
        for (int off = 0; off < 4; off += 2)
        begin
            add($sformatf("lh_off%0d", off), load_row(mem_op_pkg::LH, off));
            add($sformatf("lhu_off%0d", off), load_row(mem_op_pkg::LHU, off));
            add($sformatf("sh_off%0d", off), store_row(mem_op_pkg::SH, off));
        end
        add("lw", load_row(mem_op_pkg::LW, 0));
        add("sw", store_row(mem_op_pkg::SW, 0));
        add("nop", blank_row());

        // priority with several flags set
        add("prio_trap", excep_row(5'b11111, 0, 0, 0, 0, 0, 32'h0d));
        add("prio_ov", excep_row(5'b11011, 0, 0, 0, 0, 0, 32'h0c));
        add("prio_sys", excep_row(5'b10011, 0, 0, 0, 0, 0, 32'h08));
        add("prio_inv", excep_row(5'b10010, 0, 0, 0, 0, 0, 32'h0a));
        add("prio_eret", excep_row(5'b10000, 0, 0, 0, 0, 0, 32'h0e));
        add("int_direct", excep_row(5'b11111, 32'h101, 32'h100, 0, 0, 0, 32'h01));
        add("int_fwd_status", excep_row(5'b0, 32'h0, 32'h100, 1, 5'd12, 32'h101, 32'h01));
        add("int_fwd_cause", excep_row(5'b0, 32'h201, 32'h0, 1, 5'd13, 32'h200, 32'h01));
        add("int_exl", excep_row(5'b0, 32'h103, 32'h100, 0, 0, 0, 32'h0));
        add("cause_hw_bits", excep_row(5'b0, 32'h401, 32'h0, 1, 5'd13, 32'h400, 32'h0));
        add("status_fwd_mask", excep_row(5'b0, 32'h101, 32'h100, 1, 5'd12, 32'h100, 32'h0));
        r = excep_row(5'b11111, 0, 0, 0, 0, 0, 32'h0);
        r.inst_addr = 32'h0;        // bubble never raises
        add("bubble", r);

        add("sw_cancel", cancel(store_row(mem_op_pkg::SW, 0)));

        // ll / sc sequences
        add("ll", load_row(mem_op_pkg::LL, 0));
        r = store_row(mem_op_pkg::SW, 0);
        r.op        = mem_op_pkg::SC;
        r.wreg      = 1'b1;
        r.exp_wreg  = 1'b1;
        r.exp_wdata = 32'h1;
        add("sc_pass", r);
        r = blank_row();
        r.op        = mem_op_pkg::SC;
        r.exp_wdata = 32'h0;
        add("sc_fail", r);
        add("ll_cancel", cancel(load_row(mem_op_pkg::LL, 0)));
        add("sc_after_cancel", r);
        add("ll_again", load_row(mem_op_pkg::LL, 0));
        r = blank_row();
        r.rst       = 1'b1;
        r.exp_wreg  = 1'b0;
        r.exp_wdata = 32'h0;
        add("reset_mid", r);
        r = blank_row();
        r.op        = mem_op_pkg::SC;
        r.exp_wdata = 32'h0;
        add("sc_after_reset", r);
    endtask

    // ------------------------------------------------------------------------
    // drive and check
    // ------------------------------------------------------------------------
    task automatic apply_row(input row_t r);
        rst_i        = r.rst;
        inst_addr    = r.inst_addr;
        aluop        = r.op;
        mem_addr     = r.addr;
        reg2         = r.reg2;
        wdata        = r.wdata;
        wd           = r.wd;
        wreg         = r.wreg;
        excep_flags  = r.flags;
        cp0_status   = r.status;
        cp0_cause    = r.cause;
        wb_cp0_we    = r.cp0_we;
        wb_cp0_waddr = r.cp0_waddr;
        wb_cp0_wdata = r.cp0_wdata;
        cur_rdata    = r.rdata;
    endtask

    task automatic check(input int idx, input string sig, input logic [31:0] exp,
                         input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("ERR t=%0t row %0d %s exp=%h got=%h", $time, idx, sig, exp, act);
            errors++;
            row_bad[idx] = 1'b1;
        end
    endtask

    task automatic check_comb(input int i);
        check(i, "mem_ce_o", 32'(rows[i].exp_ce), 32'(mem_ce));
        check(i, "mem_we_o", 32'(rows[i].exp_we), 32'(mem_we));
        check(i, "mem_sel_o", 32'(rows[i].exp_sel), 32'(mem_sel));
        check(i, "mem_addr_o", rows[i].exp_addr, mem_addr_out);
        check(i, "mem_data_o", rows[i].exp_mdata, mem_wdata_out);
        check(i, "excep_code_o", rows[i].exp_code, 32'(excep_code));
    endtask

    task automatic check_wb(input int i);
        check(i, "wb_wd_o", 32'(rows[i].wd), 32'(wb_wd));
        check(i, "wb_wreg_o", 32'(rows[i].exp_wreg), 32'(wb_wreg));
        check(i, "wb_wdata_o", rows[i].exp_wdata, wb_wdata);
        $display("row %0d %s: %s", i, names[i], row_bad[i] ? "mismatch" : "ok");
    endtask

    initial
    begin
        void'($urandom(32'hd3aa));
        rst_i        = 1'b1;
        inst_addr    = 32'h0;
        aluop        = mem_op_pkg::NOP;
        mem_addr     = 32'h0;
        reg2         = 32'h0;
        wdata        = 32'h0;
        wd           = 5'd0;
        wreg         = 1'b0;
        excep_flags  = 5'b0;
        cp0_status   = 32'h0;
        cp0_cause    = 32'h0;
        wb_cp0_we    = 1'b0;
        wb_cp0_waddr = 5'd0;
        wb_cp0_wdata = 32'h0;
        cur_rdata    = 32'h0;
        build_table();
        table_ready = 1;

        repeat (8) @(posedge clk);
        #1;
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i]);
            #8;                     // 1 ns before the next edge
            if (i > 0)
                check_wb(i - 1);
            check_comb(i);
            @(posedge clk);
            #1;
        end
        #8;
        check_wb(rows.size() - 1);

        $display("rows=%0d checks=%0d errors=%0d", rows.size(), checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog sized from the table length
    initial
    begin
        wait (table_ready);
        #((rows.size() + 8 + 20) * 10);
        $display("watchdog expired before all rows were applied");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/mem_op_pkg.sv
common/cp0_pkg.sv
lsu/ram_request.sv
lsu/load_align.sv
excep/excep_arbiter.sv
logic/llsc_ctrl.sv
logic/mem_wb_reg.sv
logic/mem_stage.sv
verif/tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_stage -o sim_mem_stage

./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
